/* tb.f */
+incdir+src
src/soc_pkg.sv
src/soc_reset_ctrl.sv
src/pi1_decoder.sv
src/dev_table.sv
src/gpio_port.sv
src/activity_led.sv
src/soc_top.sv
bench/soc_tb.sv

/* Makefile */
# Verilator build, run and lint for the SoC glue

VERILATOR ?= verilator
TOP ?= soc_tb
RTL_TOP ?= soc_top
FILELIST ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall
PASS_MSG ?= STATUS: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Passes only if the pass line shows up in the simulation output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* bench/soc_tb.sv */
// Testbench for the SoC glue top level
// Reset sequencing, bus table, GPIO interrupt and activity checks
`timescale 1ns/1ps
`include "soc_settings.svh"

module soc_tb;

	localparam logic [31:0] SEED = 32'hd46c_d53c;
	localparam int TABLE_LEN = 15;
	localparam int RELEASE_LIMIT = (1 << `RST_CNTR_BITSZ) + 2;
	// The down-counter starts from all ones once lock and reset clear
	localparam int RELEASE_MIN = (1 << `RST_CNTR_BITSZ) - 1;
	// Three reset releases and the power-off hold plus bus and LED traffic
	localparam int CYCLE_LIMIT = 4 * ((1 << `RST_CNTR_BITSZ) + 4) + 8 * TABLE_LEN
		+ 4 * (1 << `ACTIVITY_CNTR_BITSZ);
	localparam logic [31:0] GPIO_IN_ADDR = `DEVTBL_MAPSZ;
	localparam logic [31:0] GPIO_OUT_ADDR = `DEVTBL_MAPSZ + 4;
	localparam logic [31:0] INVALID_BASE = `DEVTBL_MAPSZ + `GPIO_MAPSZ;
	localparam soc_pkg::gpio_word_t GPIO_IN_PAT = 16'h5a3c;
	localparam soc_pkg::gpio_word_t GPIO_FLIP = 16'h0180;

	typedef struct packed {
		soc_pkg::pi1_op_t op;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [31:0] exp_data;
		logic chk_data;
	} bus_entry_t;

	logic clk_2x_w;
	logic rst_p;
	logic pll_locked;
	logic irq_ack;
	logic irq;
	logic activity;
	logic sys_rst;
	soc_pkg::pi1_req_t m_req;
	soc_pkg::pi1_rsp_t m_rsp;
	soc_pkg::gpio_word_t gpio_in;
	soc_pkg::gpio_word_t gpio_out;
	soc_pkg::gpio_word_t gpio_model;
	bus_entry_t bus_tbl [TABLE_LEN];
	int errors;
	int act_pulses;
	int cycle_cnt;

	soc_top dut_i (
		.clk_2x_w     (clk_2x_w),
		.rst_p        (rst_p),
		.pll_locked_i (pll_locked),
		.m_req_i      (m_req),
		.m_rsp_o      (m_rsp),
		.gpio_i       (gpio_in),
		.gpio_o       (gpio_out),
		.irq_o        (irq),
		.irq_ack_i    (irq_ack),
		.activity_o   (activity),
		.sys_rst_o    (sys_rst)
	);

	initial begin
		clk_2x_w = 1'b0;
		forever #20 clk_2x_w = ~clk_2x_w;
	end

	always @(negedge clk_2x_w) begin
		if (activity === 1'b1) begin
			act_pulses++;
		end
	end

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("** Error: %s = 0x%h, expected 0x%h at %0t", name, got, exp, $time);
			errors++;
		end
	endtask

	// One request cycle with the answer sampled one cycle later
	task automatic bus_transfer(input soc_pkg::pi1_op_t op, input logic [31:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata);
		soc_pkg::pi1_req_t req;
		req.op = op;
		req.addr = addr[31:2];
		req.data = wdata;
		req.sel = '1;
		@(posedge clk_2x_w);
		m_req <= req;
		@(negedge clk_2x_w);
		check_value("m_rsp_o.rdy (request cycle)", 32'(m_rsp.rdy), 32'd0);
		@(posedge clk_2x_w);
		m_req <= '0;
		@(negedge clk_2x_w);
		check_value("m_rsp_o.rdy", 32'(m_rsp.rdy), 32'd1);
		rdata = m_rsp.data;
	endtask

	task automatic set_entry(input int idx, input soc_pkg::pi1_op_t op,
			input logic [31:0] addr, input logic [31:0] wdata,
			input logic [31:0] exp_data, input logic chk);
		bus_tbl[idx] = '{op, addr, wdata, exp_data, chk};
	endtask

	// Count word followed by id with useintr in bit 31 and map size per slave
	task automatic build_bus_table();
		logic [31:0] wr0;
		logic [31:0] wr1;
		wr0 = $urandom();
		wr1 = $urandom();
		set_entry(0, soc_pkg::PI1_READ, 32'h00, 0, `SLAVE_COUNT, 1'b1);
		set_entry(1, soc_pkg::PI1_READ, 32'h04, 0, `DEVTBL_ID, 1'b1);
		set_entry(2, soc_pkg::PI1_READ, 32'h08, 0, `DEVTBL_MAPSZ, 1'b1);
		set_entry(3, soc_pkg::PI1_READ, 32'h0c, 0, 32'h8000_0000 | `GPIO_ID, 1'b1);
		set_entry(4, soc_pkg::PI1_READ, 32'h10, 0, `GPIO_MAPSZ, 1'b1);
		set_entry(5, soc_pkg::PI1_READ, 32'h14, 0, `INVALID_ID, 1'b1);
		set_entry(6, soc_pkg::PI1_READ, 32'h18, 0, `INVALID_MAPSZ, 1'b1);
		set_entry(7, soc_pkg::PI1_READ, 32'h1c, 0, 0, 1'b1);
		set_entry(8, soc_pkg::PI1_WRITE, GPIO_OUT_ADDR, wr0, 0, 1'b0);
		set_entry(9, soc_pkg::PI1_READ, GPIO_OUT_ADDR, 0, {16'd0, wr0[15:0]}, 1'b1);
		set_entry(10, soc_pkg::PI1_READ, GPIO_IN_ADDR, 0, {16'd0, GPIO_IN_PAT}, 1'b1);
		// Read-write returns the old output value
		set_entry(11, soc_pkg::PI1_READWRITE, GPIO_OUT_ADDR, wr1, {16'd0, wr0[15:0]}, 1'b1);
		set_entry(12, soc_pkg::PI1_READ, GPIO_OUT_ADDR, 0, {16'd0, wr1[15:0]}, 1'b1);
		set_entry(13, soc_pkg::PI1_READ, INVALID_BASE, 0, 0, 1'b1);
		set_entry(14, soc_pkg::PI1_READ, 32'hffff_fffc, 0, 0, 1'b1);
		gpio_model = wr1[15:0];
	endtask

	task automatic run_bus_table();
		logic [31:0] rdata;
		for (int i = 0; i < TABLE_LEN; i++) begin
			bus_transfer(bus_tbl[i].op, bus_tbl[i].addr, bus_tbl[i].wdata, rdata);
			if (bus_tbl[i].chk_data) begin
				check_value($sformatf("m_rsp_o.data [entry %0d]", i), rdata,
					bus_tbl[i].exp_data);
			end
		end
		check_value("gpio_o", 32'(gpio_out), 32'(gpio_model));
	endtask

	task automatic wait_reset_release(input string what);
		int cycles;
		cycles = 0;
		do begin
			@(negedge clk_2x_w);
			cycles++;
		end while (sys_rst !== 1'b0 && cycles < RELEASE_LIMIT);
		if (sys_rst !== 1'b0) begin
			$display("%s: sys_rst_o did not fall within %0d cycles", what, RELEASE_LIMIT);
			errors++;
		end else if (cycles < RELEASE_MIN) begin
			$display("%s: sys_rst_o fell after only %0d cycles", what, cycles);
			errors++;
		end
	endtask

	// Any wrong value seen on irq_o over the window
	task automatic hold_irq(input logic exp, input int cycles);
		logic seen;
		seen = exp;
		repeat (cycles) begin
			@(negedge clk_2x_w);
			if (irq !== exp) begin
				seen = irq;
			end
		end
		check_value("irq_o (held)", 32'(seen), 32'(exp));
	endtask

	task automatic power_on_reset();
		@(negedge clk_2x_w);
		check_value("sys_rst_o (rst_p high)", 32'(sys_rst), 32'd1);
		@(posedge clk_2x_w);
		rst_p <= 1'b0;
		repeat (5) begin
			@(negedge clk_2x_w);
			check_value("sys_rst_o (pll unlocked)", 32'(sys_rst), 32'd1);
		end
		@(posedge clk_2x_w);
		pll_locked <= 1'b1;
		wait_reset_release("Power-on reset");
		check_value("gpio_o", 32'(gpio_out), 32'd0);
		check_value("irq_o", 32'(irq), 32'd0);
		check_value("activity_o", 32'(activity), 32'd0);
		check_value("m_rsp_o.rdy", 32'(m_rsp.rdy), 32'd0);
	endtask

	task automatic gpio_interrupt();
		logic [31:0] rdata;
		hold_irq(1'b0, 8);
		@(posedge clk_2x_w);
		gpio_in <= GPIO_IN_PAT ^ GPIO_FLIP;
		@(negedge clk_2x_w);
		@(negedge clk_2x_w);
		check_value("irq_o (change sampled)", 32'(irq), 32'd0);
		@(negedge clk_2x_w);
		check_value("irq_o", 32'(irq), 32'd1);
		hold_irq(1'b1, 4);
		@(posedge clk_2x_w);
		irq_ack <= 1'b1;
		@(posedge clk_2x_w);
		irq_ack <= 1'b0;
		@(negedge clk_2x_w);
		check_value("irq_o (after ack)", 32'(irq), 32'd0);
		hold_irq(1'b0, 8);
		bus_transfer(soc_pkg::PI1_READ, GPIO_IN_ADDR, 0, rdata);
		check_value("m_rsp_o.data (gpio_i)", rdata, 32'(GPIO_IN_PAT ^ GPIO_FLIP));
	endtask

	task automatic warm_reset();
		logic [31:0] rdata;
		// Leave a change interrupt pending for the reset to clear
		@(posedge clk_2x_w);
		gpio_in <= GPIO_IN_PAT;
		repeat (3) @(negedge clk_2x_w);
		check_value("irq_o (pending)", 32'(irq), 32'd1);
		bus_transfer(soc_pkg::PI1_WRITE, 32'h0, 32'h2, rdata);
		@(negedge clk_2x_w);
		check_value("sys_rst_o (warm request)", 32'(sys_rst), 32'd1);
		wait_reset_release("Warm reset");
		gpio_model = '0;
		check_value("gpio_o", 32'(gpio_out), 32'(gpio_model));
		check_value("irq_o", 32'(irq), 32'd0);
	endtask

	task automatic activity_pulses();
		logic [31:0] rdata;
		@(posedge clk_2x_w);
		act_pulses = 0;
		bus_transfer(soc_pkg::PI1_READ, 32'h0, 0, rdata);
		repeat (8) @(posedge clk_2x_w);
		// Second request lands inside the dim period
		bus_transfer(soc_pkg::PI1_READ, 32'h0, 0, rdata);
		repeat (4) @(negedge clk_2x_w);
		check_value("activity_o pulse count", act_pulses, 32'd1);
		repeat (1 << `ACTIVITY_CNTR_BITSZ) @(posedge clk_2x_w);
		bus_transfer(soc_pkg::PI1_READ, 32'h0, 0, rdata);
		repeat (4) @(negedge clk_2x_w);
		check_value("activity_o pulse count", act_pulses, 32'd2);
	endtask

	task automatic power_off_recovery();
		logic [31:0] rdata;
		logic held;
		held = 1'b1;
		bus_transfer(soc_pkg::PI1_WRITE, 32'h0, 32'h1, rdata);
		// Longer than any counted release
		repeat (RELEASE_LIMIT + 2) begin
			@(negedge clk_2x_w);
			if (sys_rst !== 1'b1) begin
				held = 1'b0;
			end
		end
		check_value("sys_rst_o (power-off hold)", 32'(held), 32'd1);
		@(posedge clk_2x_w);
		rst_p <= 1'b1;
		repeat (2) @(posedge clk_2x_w);
		rst_p <= 1'b0;
		wait_reset_release("Power-off recovery");
		bus_transfer(soc_pkg::PI1_READ, 32'h0, 0, rdata);
		check_value("m_rsp_o.data (after recovery)", rdata, `SLAVE_COUNT);
	endtask

	initial begin
		void'($urandom(SEED));
		rst_p = 1'b1;
		pll_locked = 1'b0;
		m_req = '0;
		gpio_in = GPIO_IN_PAT;
		irq_ack = 1'b0;
		errors = 0;
		act_pulses = 0;
		build_bus_table();
		power_on_reset();
		run_bus_table();
		gpio_interrupt();
		warm_reset();
		activity_pulses();
		power_off_recovery();
		$display("Errors: %0d", errors);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < CYCLE_LIMIT) begin
			@(posedge clk_2x_w);
			cycle_cnt++;
		end
		$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

/* src/soc_top.sv */
// SoC glue top level
// Reset sequencer, bus decoder, device table, GPIO and activity LED
`timescale 1ns/1ps
`include "soc_settings.svh"

module soc_top (
	input  logic                 clk_2x_w,
	input  logic                 rst_p,
	input  logic                 pll_locked_i,
	input  soc_pkg::pi1_req_t    m_req_i,
	output soc_pkg::pi1_rsp_t    m_rsp_o,
	input  soc_pkg::gpio_word_t  gpio_i,
	output soc_pkg::gpio_word_t  gpio_o,
	output logic                 irq_o,
	input  logic                 irq_ack_i,
	output logic                 activity_o,
	output logic                 sys_rst_o
);

	soc_pkg::sw_reset_t sw_reset_w;
	soc_pkg::pi1_req_t [`SLAVE_COUNT-2:0] s_req_w;
	soc_pkg::pi1_rsp_t [`SLAVE_COUNT-2:0] s_rsp_w;

	// Any master op counts as traffic for the LED
	wire req_seen_w = (m_req_i.op != soc_pkg::PI1_NONE);

	soc_reset_ctrl reset_ctrl_i (
		.clk_2x_w     (clk_2x_w),
		.rst_p        (rst_p),
		.pll_locked_i (pll_locked_i),
		.sw_reset_i   (sw_reset_w),
		.sys_rst_o    (sys_rst_o)
	);

	pi1_decoder decoder_i (
		.clk_2x_w  (clk_2x_w),
		.sys_rst_i (sys_rst_o),
		.m_req_i   (m_req_i),
		.m_rsp_o   (m_rsp_o),
		.s_req_o   (s_req_w),
		.s_rsp_i   (s_rsp_w)
	);

	// Slave 0
	dev_table dev_table_i (
		.clk_2x_w   (clk_2x_w),
		.sys_rst_i  (sys_rst_o),
		.req_i      (s_req_w[0]),
		.rsp_o      (s_rsp_w[0]),
		.sw_reset_o (sw_reset_w)
	);

	// Slave 1
	gpio_port gpio_i0 (
		.clk_2x_w  (clk_2x_w),
		.sys_rst_i (sys_rst_o),
		.req_i     (s_req_w[1]),
		.rsp_o     (s_rsp_w[1]),
		.gpio_i    (gpio_i),
		.gpio_o    (gpio_o),
		.irq_o     (irq_o),
		.irq_ack_i (irq_ack_i)
	);

	activity_led activity_i (
		.clk_2x_w   (clk_2x_w),
		.sys_rst_i  (sys_rst_o),
		.req_seen_i (req_seen_w),
		.activity_o (activity_o)
	);

endmodule

/* src/activity_led.sv */
// Bus activity indicator, stretched and dimmed by a down-counter
`timescale 1ns/1ps
`include "soc_settings.svh"

module activity_led (
	input  logic  clk_2x_w,
	input  logic  sys_rst_i,
	input  logic  req_seen_i,
	output logic  activity_o
);

	logic [`ACTIVITY_CNTR_BITSZ-1:0] cntr_r;
	logic activity_r;

	always_ff @(posedge clk_2x_w) begin
		if (sys_rst_i) begin
			cntr_r <= '0;
			activity_r <= 1'b0;
		end else if (cntr_r != '0) begin
			// Dim period, traffic is ignored
			activity_r <= 1'b0;
			cntr_r <= cntr_r - 1'b1;
		end else if (req_seen_i) begin
			activity_r <= 1'b1;
			cntr_r <= '1;
		end else begin
			activity_r <= 1'b0;
		end
	end

	assign activity_o = activity_r;

endmodule

/* src/gpio_port.sv */
// GPIO slave with output register, input sampler and change interrupt
`timescale 1ns/1ps
`include "soc_settings.svh"

module gpio_port (
	input  logic                 clk_2x_w,
	input  logic                 sys_rst_i,
	input  soc_pkg::pi1_req_t    req_i,
	output soc_pkg::pi1_rsp_t    rsp_o,
	input  soc_pkg::gpio_word_t  gpio_i,
	output soc_pkg::gpio_word_t  gpio_o,
	output logic                 irq_o,
	input  logic                 irq_ack_i
);

	localparam int OFS_W = $clog2(`GPIO_MAPSZ) - 2;

	logic [OFS_W-1:0] ofs_w;
	logic rd_w;
	logic wr_w;
	logic change_w;
	soc_pkg::gpio_word_t sample_r;
	soc_pkg::gpio_word_t prev_r;
	soc_pkg::gpio_word_t out_r;
	logic irq_r;
	soc_pkg::arch_word_t rd_data_w;
	soc_pkg::arch_word_t data_r;
	logic rdy_r;

	assign ofs_w = req_i.addr[OFS_W-1:0];
	assign rd_w = (req_i.op == soc_pkg::PI1_READ) || (req_i.op == soc_pkg::PI1_READWRITE);
	assign wr_w = (req_i.op == soc_pkg::PI1_WRITE) || (req_i.op == soc_pkg::PI1_READWRITE);
	assign change_w = (sample_r != prev_r);

	// Word 0 is the input sample, word 1 the output register
	always_comb begin
		rd_data_w = '0;
		if (ofs_w == OFS_W'(0)) begin
			rd_data_w = soc_pkg::arch_word_t'(sample_r);
		end else if (ofs_w == OFS_W'(1)) begin
			rd_data_w = soc_pkg::arch_word_t'(out_r);
		end
	end

	always_ff @(posedge clk_2x_w) begin
		if (rd_w) begin
			data_r <= rd_data_w;
		end
	end

	always_ff @(posedge clk_2x_w) begin
		if (sys_rst_i) begin
			// Both stages load the pins so release raises no interrupt
			sample_r <= gpio_i;
			prev_r <= gpio_i;
			out_r <= '0;
			irq_r <= 1'b0;
			rdy_r <= 1'b0;
		end else begin
			sample_r <= gpio_i;
			prev_r <= sample_r;
			rdy_r <= (req_i.op != soc_pkg::PI1_NONE);
			if (change_w) begin
				irq_r <= 1'b1;
			end else if (irq_ack_i) begin
				irq_r <= 1'b0;
			end
			if (wr_w && (ofs_w == OFS_W'(1))) begin
				for (int i = 0; i < `GPIO_COUNT; i++) begin
					if (req_i.sel[i / 8]) begin
						out_r[i] <= req_i.data[i];
					end
				end
			end
		end
	end

	assign rsp_o.data = data_r;
	assign rsp_o.rdy = rdy_r;
	assign gpio_o = out_r;
	assign irq_o = irq_r;

endmodule

/* src/dev_table.sv */
// Device table slave with the software reset request register
`timescale 1ns/1ps
`include "soc_settings.svh"

module dev_table (
	input  logic                clk_2x_w,
	input  logic                sys_rst_i,
	input  soc_pkg::pi1_req_t   req_i,
	output soc_pkg::pi1_rsp_t   rsp_o,
	output soc_pkg::sw_reset_t  sw_reset_o
);

	localparam int OFS_W = $clog2(`DEVTBL_MAPSZ) - 2;

	typedef logic [OFS_W-1:0] ofs_t;

	// Entries in slave index order
	localparam soc_pkg::dev_info_t DEV_INFO [`SLAVE_COUNT] = '{
		'{id: 16'(`DEVTBL_ID), useintr: 1'b0, mapsz: soc_pkg::arch_word_t'(`DEVTBL_MAPSZ)},
		'{id: 16'(`GPIO_ID), useintr: 1'b1, mapsz: soc_pkg::arch_word_t'(`GPIO_MAPSZ)},
		'{id: 16'(`INVALID_ID), useintr: 1'b0, mapsz: soc_pkg::arch_word_t'(`INVALID_MAPSZ)}
	};

	ofs_t ofs_w;
	logic rd_w;
	logic wr_w;
	soc_pkg::arch_word_t rd_data_w;
	soc_pkg::arch_word_t data_r;
	logic rdy_r;
	soc_pkg::sw_reset_t sw_reset_r;

	assign ofs_w = req_i.addr[OFS_W-1:0];
	assign rd_w = (req_i.op == soc_pkg::PI1_READ) || (req_i.op == soc_pkg::PI1_READWRITE);
	assign wr_w = (req_i.op == soc_pkg::PI1_WRITE) || (req_i.op == soc_pkg::PI1_READWRITE);

	// Word 0 is the count, then id and map size per slave
	always_comb begin
		rd_data_w = '0;
		if (ofs_w == '0) begin
			rd_data_w = soc_pkg::arch_word_t'(`SLAVE_COUNT);
		end
		for (int k = 0; k < `SLAVE_COUNT; k++) begin
			if (ofs_w == ofs_t'(1 + 2 * k)) begin
				rd_data_w[15:0] = DEV_INFO[k].id;
				rd_data_w[`ARCHBITSZ-1] = DEV_INFO[k].useintr;
			end
			if (ofs_w == ofs_t'(2 + 2 * k)) begin
				rd_data_w = DEV_INFO[k].mapsz;
			end
		end
	end

	always_ff @(posedge clk_2x_w) begin
		if (rd_w) begin
			data_r <= rd_data_w;
		end
	end

	always_ff @(posedge clk_2x_w) begin
		if (sys_rst_i) begin
			rdy_r <= 1'b0;
			sw_reset_r <= '0;
		end else begin
			rdy_r <= (req_i.op != soc_pkg::PI1_NONE);
			// Reset requests last a single cycle
			sw_reset_r <= '0;
			if (wr_w && (ofs_w == '0) && req_i.sel[0]) begin
				sw_reset_r.rst0 <= req_i.data[0];
				sw_reset_r.rst1 <= req_i.data[1];
			end
		end
	end

	assign rsp_o.data = data_r;
	assign rsp_o.rdy = rdy_r;
	assign sw_reset_o = sw_reset_r;

endmodule

/* src/pi1_decoder.sv */
// Peripheral bus address decoder with response mux and invalid device
`timescale 1ns/1ps
`include "soc_settings.svh"

module pi1_decoder (
	input  logic                                  clk_2x_w,
	input  logic                                  sys_rst_i,
	input  soc_pkg::pi1_req_t                     m_req_i,
	output soc_pkg::pi1_rsp_t                     m_rsp_o,
	output soc_pkg::pi1_req_t [`SLAVE_COUNT-2:0]  s_req_o,
	input  soc_pkg::pi1_rsp_t [`SLAVE_COUNT-2:0]  s_rsp_i
);

	// The invalid device takes the last slave index
	localparam soc_pkg::slave_idx_t SLV_DEVTBL = 2'd0;
	localparam soc_pkg::slave_idx_t SLV_GPIO = 2'd1;
	localparam soc_pkg::slave_idx_t SLV_INVALID = soc_pkg::slave_idx_t'(`SLAVE_COUNT - 1);

	// Word address bounds, map starts at 0 with the device table
	localparam soc_pkg::pi1_addr_t GPIO_BASE = soc_pkg::pi1_addr_t'(`DEVTBL_MAPSZ >> 2);
	localparam soc_pkg::pi1_addr_t GPIO_END =
		soc_pkg::pi1_addr_t'((`DEVTBL_MAPSZ + `GPIO_MAPSZ) >> 2);

	soc_pkg::slave_idx_t hit_idx_w;
	soc_pkg::slave_idx_t sel_idx_r;
	logic req_valid_w;
	logic inv_rdy_r;

	assign req_valid_w = (m_req_i.op != soc_pkg::PI1_NONE);

	always_comb begin
		if (m_req_i.addr < GPIO_BASE) begin
			hit_idx_w = SLV_DEVTBL;
		end else if (m_req_i.addr < GPIO_END) begin
			hit_idx_w = SLV_GPIO;
		end else begin
			hit_idx_w = SLV_INVALID;
		end
	end

	// All slaves see the request, only the hit one gets the op
	always_comb begin
		for (int k = 0; k < `SLAVE_COUNT - 1; k++) begin
			s_req_o[k] = m_req_i;
			if (hit_idx_w != soc_pkg::slave_idx_t'(k)) begin
				s_req_o[k].op = soc_pkg::PI1_NONE;
			end
		end
	end

	always_ff @(posedge clk_2x_w) begin
		if (sys_rst_i) begin
			sel_idx_r <= SLV_INVALID;
			inv_rdy_r <= 1'b0;
		end else begin
			// Invalid device answers every unmapped access
			inv_rdy_r <= req_valid_w && (hit_idx_w == SLV_INVALID);
			if (req_valid_w) begin
				sel_idx_r <= hit_idx_w;
			end
		end
	end

	// Pick the reply of the slave addressed last cycle
	always_comb begin
		case (sel_idx_r)
			SLV_DEVTBL: begin
				m_rsp_o = s_rsp_i[0];
			end
			SLV_GPIO: begin
				m_rsp_o = s_rsp_i[1];
			end
			default: begin
				m_rsp_o.data = '0;
				m_rsp_o.rdy = inv_rdy_r;
			end
		endcase
	end

endmodule

/* src/soc_reset_ctrl.sv */
// Reset sequencer with PLL lock gating, down-counter and power-off latch
`timescale 1ns/1ps
`include "soc_settings.svh"

module soc_reset_ctrl (
	input  logic                clk_2x_w,
	input  logic                rst_p,
	input  logic                pll_locked_i,
	input  soc_pkg::sw_reset_t  sw_reset_i,
	output logic                sys_rst_o
);

	soc_pkg::reset_state_t state_r;
	logic [`RST_CNTR_BITSZ-1:0] cntr_r;
	logic sw_cold_w;
	logic sw_warm_w;
	logic sw_pwroff_w;

	// Software request decode
	assign sw_cold_w = sw_reset_i.rst0 && sw_reset_i.rst1;
	assign sw_warm_w = !sw_reset_i.rst0 && sw_reset_i.rst1;
	assign sw_pwroff_w = sw_reset_i.rst0 && !sw_reset_i.rst1;

	always_ff @(posedge clk_2x_w) begin
		if (rst_p) begin
			state_r <= soc_pkg::RST_HOLD;
			cntr_r <= '1;
		end else if (state_r == soc_pkg::RST_OFF) begin
			// Only rst_p brings the system back from power-off
			state_r <= soc_pkg::RST_OFF;
		end else if (!pll_locked_i) begin
			state_r <= soc_pkg::RST_HOLD;
			cntr_r <= '1;
		end else if (sw_pwroff_w) begin
			state_r <= soc_pkg::RST_OFF;
		end else if (sw_cold_w || sw_warm_w) begin
			// Cold reset restarts the count just like warm reset
			state_r <= soc_pkg::RST_COUNT;
			cntr_r <= '1;
		end else begin
			case (state_r)
				soc_pkg::RST_HOLD: begin
					state_r <= soc_pkg::RST_COUNT;
				end
				soc_pkg::RST_COUNT: begin
					if (cntr_r == '0) begin
						state_r <= soc_pkg::RST_RUN;
					end else begin
						cntr_r <= cntr_r - 1'b1;
					end
				end
				default: begin
					state_r <= state_r;
				end
			endcase
		end
	end

	// Raw conditions act at once, the state machine covers the rest
	assign sys_rst_o = rst_p || !pll_locked_i || (state_r != soc_pkg::RST_RUN);

endmodule

/* src/soc_pkg.sv */
// Shared types of the SoC glue
// Bus words and structs, device table entries, reset states
`include "soc_settings.svh"

package soc_pkg;

	// Plain vectors with a meaning of their own
	typedef logic [`ARCHBITSZ-1:0] arch_word_t;
	typedef logic [`ARCHBITSZ-3:0] pi1_addr_t;
	typedef logic [(`ARCHBITSZ/8)-1:0] pi1_sel_t;
	typedef logic [`GPIO_COUNT-1:0] gpio_word_t;
	typedef logic [1:0] slave_idx_t;

	// Peripheral bus operations
	typedef enum logic [1:0] {
		PI1_NONE = 2'd0,
		PI1_READWRITE = 2'd1,
		PI1_READ = 2'd2,
		PI1_WRITE = 2'd3
	} pi1_op_t;

	// Master to slave request, valid for one cycle
	typedef struct packed {
		pi1_op_t op;
		pi1_addr_t addr;
		arch_word_t data;
		pi1_sel_t sel;
	} pi1_req_t;

	// Slave answer, one cycle after the request
	typedef struct packed {
		arch_word_t data;
		logic rdy;
	} pi1_rsp_t;

	// One device table entry
	typedef struct packed {
		logic [15:0] id;
		logic useintr;
		arch_word_t mapsz;
	} dev_info_t;

	// Reset request bits written by software
	typedef struct packed {
		logic rst1;
		logic rst0;
	} sw_reset_t;

	typedef enum logic [1:0] {
		RST_HOLD,
		RST_COUNT,
		RST_RUN,
		RST_OFF
	} reset_state_t;

endpackage

/* src/soc_settings.svh */
// Bus width, counter sizes, device ids and map sizes of the SoC glue
`ifndef SOC_SETTINGS_SVH
`define SOC_SETTINGS_SVH

// Width of one bus data word
`define ARCHBITSZ 32

// Number of general-purpose pins
`define GPIO_COUNT 16

// Power-on and warm reset down-counter width
`define RST_CNTR_BITSZ 16

// Dim counter of the activity indicator
`define ACTIVITY_CNTR_BITSZ 7

// Bus slaves, the invalid device included
`define SLAVE_COUNT 3

// Device ids reported by the device table
`define DEVTBL_ID 7
`define GPIO_ID 6
`define INVALID_ID 0

// Map sizes in bytes
// Each one is a power of two
`define DEVTBL_MAPSZ 'h1000
`define GPIO_MAPSZ 'h1000
`define INVALID_MAPSZ 'h1000

`endif
